// File: flist.f
+incdir+hw
hw/burst_pkg.sv
hw/slot_if.sv
hw/burst_allocator.sv
hw/burst_slot.sv
hw/burst_sequencer.sv
hw/burst_engine.sv
sim/burst_engine_checker.sv
sim/burst_engine_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = burst_engine_tb
FLIST = flist.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

// File: sim/burst_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

module burst_engine_tb import burst_pkg::*; ();
	localparam int MAX_CYCLES = 2000;
	localparam int RET_WAIT   = 600;  // per test, cycles

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 req_valid;
	req_type_e            req_type;
	logic [1:0]           req_bg;
	logic [1:0]           req_bank;
	logic [15:0]          req_row;
	logic [9:0]           req_col;
	logic [`DATA_W-1:0]   req_data;
	logic [`INDEX_W-1:0]  req_index;
	logic                 req_ready;
	logic                 cs_n;
	logic [13:0]          ca;
	logic [`DATA_W-1:0]   dq_out;
	logic                 dq_oe;
	logic [`DATA_W/8-1:0] dm_n;
	logic [`DATA_W-1:0]   dq_in = '0;
	logic                 ret_valid;
	req_type_e            ret_type;
	logic [`INDEX_W-1:0]  ret_index;
	logic [`DATA_W-1:0]   ret_data;

	integer seed;
	int     errors    = 0;
	int     tests_run = 0;
	int     stalls    = 0;
	int     cycles    = 0;

	// memory model, keyed {bg, bank, row, col}
	logic [`DATA_W-1:0] mem [bit [29:0]];
	logic [15:0]        open_row [16];
	ddr_cmd_e           pend_cmd  = cmd_none;
	logic [3:0]         pend_bank;
	logic [3:0]         pend_row_lo;
	logic [29:0]        burst_base;
	int                 rd_cnt    = -1;
	int                 wr_cnt    = -1;
	int                 wr_beat;
	int                 act_count = 0;
	int                 rw_count  = 0;
	int                 pre_count = 0;

	logic [`INDEX_W-1:0] ret_idx_q  [$];
	req_type_e           ret_type_q [$];
	logic [`DATA_W-1:0]  ret_data_q [$];

	burst_engine uut (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [`DATA_W-1:0] mem_word(input logic [29:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr[15:0] ^ {2'b00, addr[29:16]}; // fill over the whole address
	endfunction

	// decodes cs_n/ca pairs, serves read beats and records write beats
	always @(negedge clk) begin
		if (!rst_n) begin
			pend_cmd = cmd_none;
			rd_cnt   = -1;
			wr_cnt   = -1;
			dq_in    = '0;
		end else begin
			dq_in = '0;
			if (rd_cnt >= 0) begin
				rd_cnt++;
				if (rd_cnt > `RD_LAT && rd_cnt <= `RD_LAT + `BURST_LEN)
					dq_in = mem_word({burst_base[29:4], 4'(rd_cnt - `RD_LAT - 1)});
				else if (rd_cnt > `RD_LAT + `BURST_LEN)
					rd_cnt = -1;
			end
			if (wr_cnt >= 0)
				wr_cnt++;
			if (dq_oe) begin
				wr_beat = wr_cnt - `WR_LAT - 1;
				if (wr_cnt < 0 || wr_beat < 0 || wr_beat >= `BURST_LEN) begin
					$display("%0t ns: dq_oe high outside a write data window", $time);
					errors++;
				end else if (dm_n == '0) begin
					mem[{burst_base[29:4], 4'(wr_beat)}] = dq_out;
				end
			end
			if (wr_cnt > `WR_LAT + `BURST_LEN)
				wr_cnt = -1;

			if (!cs_n) begin
				pend_bank = ca[9:6];
				if (ca[1:0] == 2'b00) begin
					pend_cmd    = cmd_act;
					pend_row_lo = ca[5:2];
					act_count++;
				end else if (ca[4:0] == 5'b11101) begin
					pend_cmd = cmd_rd;
				end else if (ca[4:0] == 5'b01101) begin
					pend_cmd = cmd_wr;
				end else if (ca[5:0] == 6'b011011) begin
					pend_cmd = cmd_pre;
					pre_count++;
				end else begin
					$display("%0t ns: unknown command, ca %h", $time, ca);
					errors++;
				end
			end else if (pend_cmd != cmd_none) begin
				if (pend_cmd == cmd_act)
					open_row[pend_bank] = {ca[11:0], pend_row_lo};
				if (pend_cmd == cmd_rd || pend_cmd == cmd_wr) begin
					burst_base = {pend_bank, open_row[pend_bank], ca[7:2], 4'h0};
					rw_count++;
					if (pend_cmd == cmd_rd)
						rd_cnt = 0;
					else
						wr_cnt = 0;
				end
				pend_cmd = cmd_none;
			end
		end
	end

	// returner side, always accepts
	always @(negedge clk) begin
		if (rst_n && ret_valid) begin
			ret_idx_q.push_back(ret_index);
			ret_type_q.push_back(ret_type);
			ret_data_q.push_back(ret_data);
		end
	end

	task automatic report_mismatch(input string sig, input int exp, input int got);
		$display("[FAIL] %0t ns %s expected %0h got %0h", $time, sig, exp, got);
		errors++;
	endtask

	task automatic end_test(input string name, input int e0);
		tests_run++;
		if (errors == e0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - e0);
	endtask

	task automatic clear_returns();
		ret_idx_q.delete();
		ret_type_q.delete();
		ret_data_q.delete();
	endtask

	// called on a falling edge, returns on the falling edge after the accept
	task automatic send_req(input req_type_e t, input logic [1:0] bg, input logic [1:0] bank,
		input logic [15:0] row, input logic [9:0] col, input logic [15:0] data,
		input logic [3:0] index);
		req_valid = 1'b1;
		req_type  = t;
		req_bg    = bg;
		req_bank  = bank;
		req_row   = row;
		req_col   = col;
		req_data  = data;
		req_index = index;
		while (!req_ready) begin
			stalls++;
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic idle_cycle();
		req_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_returns(input int n);
		int waited;
		waited = 0;
		while (ret_idx_q.size() < n && waited < RET_WAIT) begin
			@(negedge clk);
			waited++;
		end
		repeat (4) @(negedge clk); // catch stray entries
		if (ret_idx_q.size() != n) begin
			$display("%0t ns: expected %0d returns but saw %0d", $time, n, ret_idx_q.size());
			errors++;
		end
	endtask

	task automatic check_reset_values();
		int e0;
		int waited;
		e0     = errors;
		waited = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (cs_n !== 1'b1) report_mismatch("cs_n", 1, int'(cs_n));
		if (ca !== '0) report_mismatch("ca", 0, int'(ca));
		if (dq_oe !== 1'b0) report_mismatch("dq_oe", 0, int'(dq_oe));
		if (dm_n !== '1) report_mismatch("dm_n", 3, int'(dm_n));
		if (ret_valid !== 1'b0) report_mismatch("ret_valid", 0, int'(ret_valid));
		if (req_ready !== 1'b0) report_mismatch("req_ready", 0, int'(req_ready));
		rst_n = 1'b1;
		while (req_ready !== 1'b1 && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (req_ready !== 1'b1) begin
			$display("%0t ns: req_ready did not rise after reset", $time);
			errors++;
		end
		end_test("reset_values", e0);
	endtask

	task automatic write_full_burst();
		int e0, acts0, rws0, pres0;
		logic [15:0] wdata [16];
		e0    = errors;
		acts0 = act_count;
		rws0  = rw_count;
		pres0 = pre_count;
		clear_returns();
		for (int i = 0; i < 16; i++) begin
			wdata[i] = 16'($random(seed));
			send_req(wr, 2'd1, 2'd2, 16'h1234, {6'h05, 4'(i)}, wdata[i], 4'(i));
		end
		idle_cycle();
		wait_returns(16);
		foreach (ret_idx_q[k]) begin
			if (ret_type_q[k] != wr) report_mismatch("ret_type", int'(wr), int'(ret_type_q[k]));
			if (ret_idx_q[k] != 4'(k)) report_mismatch("ret_index", k, int'(ret_idx_q[k]));
		end
		if (act_count - acts0 != 1) report_mismatch("activate count", 1, act_count - acts0);
		if (rw_count - rws0 != 1) report_mismatch("write count", 1, rw_count - rws0);
		if (pre_count - pres0 != 1) report_mismatch("precharge count", 1, pre_count - pres0);
		for (int i = 0; i < 16; i++) begin
			if (mem_word({2'd1, 2'd2, 16'h1234, 6'h05, 4'(i)}) != wdata[i])
				report_mismatch($sformatf("mem col %0d", i), int'(wdata[i]),
					int'(mem_word({2'd1, 2'd2, 16'h1234, 6'h05, 4'(i)})));
		end
		end_test("full_write_burst", e0);
	endtask

	task automatic read_partial_burst();
		int e0;
		int k;
		logic [3:0]  cols [5];
		logic [3:0]  idxs [5];
		logic [15:0] word [16];
		logic [3:0]  want_idx [$];
		logic [15:0] want_data [$];
		e0   = errors;
		cols = '{4'd9, 4'd2, 4'd14, 4'd5, 4'd0};
		idxs = '{4'd3, 4'd7, 4'd1, 4'd12, 4'd9};
		clear_returns();
		for (int i = 0; i < 5; i++) begin
			word[cols[i]] = 16'($random(seed));
			mem[{2'd2, 2'd1, 16'h0abc, 6'h11, cols[i]}] = word[cols[i]];
		end
		// expected order is by column
		for (int c = 0; c < 16; c++) begin
			for (int i = 0; i < 5; i++) begin
				if (cols[i] == 4'(c)) begin
					want_idx.push_back(idxs[i]);
					want_data.push_back(word[c]);
				end
			end
		end
		for (int i = 0; i < 5; i++)
			send_req(rd, 2'd2, 2'd1, 16'h0abc, {6'h11, cols[i]}, 16'h0000, idxs[i]);
		idle_cycle();
		wait_returns(5);
		k = (ret_idx_q.size() < 5) ? ret_idx_q.size() : 5;
		for (int i = 0; i < k; i++) begin
			if (ret_type_q[i] != rd) report_mismatch("ret_type", int'(rd), int'(ret_type_q[i]));
			if (ret_idx_q[i] != want_idx[i])
				report_mismatch("ret_index", int'(want_idx[i]), int'(ret_idx_q[i]));
			if (ret_data_q[i] != want_data[i])
				report_mismatch("ret_data", int'(want_data[i]), int'(ret_data_q[i]));
		end
		end_test("partial_read_burst", e0);
	endtask

	task automatic split_on_mismatch();
		int e0, acts0;
		int seen [6];
		req_type_e kind [6];
		e0    = errors;
		acts0 = act_count;
		kind  = '{rd, rd, rd, wr, wr, wr};
		clear_returns();
		send_req(rd, 2'd0, 2'd3, 16'h0040, 10'h010, 16'h0000, 4'd0);
		send_req(rd, 2'd0, 2'd3, 16'h0041, 10'h011, 16'h0000, 4'd1); // other row
		send_req(rd, 2'd0, 2'd3, 16'h0040, 10'h012, 16'h0000, 4'd2); // back to the first row
		send_req(wr, 2'd0, 2'd3, 16'h0040, 10'h013, 16'hbeef, 4'd3); // type change
		send_req(wr, 2'd0, 2'd3, 16'h0040, 10'h014, 16'h1234, 4'd4); // joins index 3
		send_req(wr, 2'd0, 2'd3, 16'h0040, 10'h013, 16'h5678, 4'd5); // column again
		idle_cycle();
		wait_returns(6);
		foreach (seen[i])
			seen[i] = 0;
		foreach (ret_idx_q[k]) begin
			if (ret_idx_q[k] > 4'd5) begin
				$display("%0t ns: unexpected ret_index %0d", $time, ret_idx_q[k]);
				errors++;
			end else begin
				seen[ret_idx_q[k]]++;
				if (ret_type_q[k] != kind[ret_idx_q[k]])
					report_mismatch("ret_type", int'(kind[ret_idx_q[k]]), int'(ret_type_q[k]));
			end
		end
		foreach (seen[i]) begin
			if (seen[i] != 1)
				report_mismatch($sformatf("returns of index %0d", i), 1, seen[i]);
		end
		if (act_count - acts0 != 5) report_mismatch("activate count", 5, act_count - acts0);
		end_test("split_on_mismatch", e0);
	endtask

	task automatic stall_on_full_slots();
		int e0, stalls0;
		int seen [8];
		logic [9:0]  cols [8];
		logic [15:0] wdata [8];
		e0      = errors;
		stalls0 = stalls;
		clear_returns();
		for (int i = 0; i < 8; i++) begin
			cols[i]  = 10'($random(seed));
			wdata[i] = 16'($random(seed));
			seen[i]  = 0;
			send_req(wr, 2'd3, 2'd0, 16'h0200 + 16'(i), cols[i], wdata[i], 4'(i));
		end
		idle_cycle();
		wait_returns(8);
		if (stalls == stalls0) begin
			$display("req_ready never dropped while the requests streamed in");
			errors++;
		end
		foreach (ret_idx_q[k]) begin
			if (ret_idx_q[k] > 4'd7) begin
				$display("%0t ns: unexpected ret_index %0d", $time, ret_idx_q[k]);
				errors++;
			end else begin
				seen[ret_idx_q[k]]++;
				if (ret_data_q[k] != wdata[ret_idx_q[k]])
					report_mismatch("ret_data", int'(wdata[ret_idx_q[k]]), int'(ret_data_q[k]));
			end
		end
		for (int i = 0; i < 8; i++) begin
			if (seen[i] != 1)
				report_mismatch($sformatf("returns of index %0d", i), 1, seen[i]);
			if (mem_word({2'd3, 2'd0, 16'h0200 + 16'(i), cols[i]}) != wdata[i])
				report_mismatch($sformatf("mem row %0h", 16'h0200 + 16'(i)), int'(wdata[i]),
					int'(mem_word({2'd3, 2'd0, 16'h0200 + 16'(i), cols[i]})));
		end
		end_test("backpressure", e0);
	endtask

	initial begin
		seed      = 32'hf810_87ac;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_type  = rd;
		req_bg    = '0;
		req_bank  = '0;
		req_row   = '0;
		req_col   = '0;
		req_data  = '0;
		req_index = '0;
		check_reset_values();
		write_full_burst();
		read_partial_burst();
		split_on_mismatch();
		stall_on_full_slots();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/burst_engine_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

module burst_engine_checker (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 cs_n,
	input logic                 dq_oe,
	input logic [`DATA_W/8-1:0] dm_n,
	input logic                 ret_valid
);

	// returner sees nothing while in reset
	ret_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !ret_valid)
		else $error("ret_valid high while rst_n is low");

	ret_dm_when_driving: assert property (@(posedge clk) disable iff (!rst_n)
		dq_oe |-> (dm_n != '1))
		else $error("dq_oe high with every dm_n bit high");

	// two-cycle command, cs_n low only in the first half
	cmd_pair_second_half: assert property (@(posedge clk) disable iff (!rst_n)
		!cs_n |=> cs_n)
		else $error("cs_n low on two cycles in a row");

endmodule

bind burst_engine burst_engine_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.cs_n      (cs_n),
	.dq_oe     (dq_oe),
	.dm_n      (dm_n),
	.ret_valid (ret_valid)
);

`default_nettype wire

// File: hw/burst_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

module burst_engine import burst_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	// from the bank arbiter
	input  logic                 req_valid,
	input  req_type_e            req_type,
	input  logic [1:0]           req_bg,
	input  logic [1:0]           req_bank,
	input  logic [15:0]          req_row,
	input  logic [9:0]           req_col,
	input  logic [`DATA_W-1:0]   req_data,
	input  logic [`INDEX_W-1:0]  req_index,
	output logic                 req_ready,
	// memory side
	output logic                 cs_n,
	output logic [13:0]          ca,
	output logic [`DATA_W-1:0]   dq_out,
	output logic                 dq_oe,
	output logic [`DATA_W/8-1:0] dm_n,
	input  logic [`DATA_W-1:0]   dq_in,
	// to the returner
	output logic                 ret_valid,
	output req_type_e            ret_type,
	output logic [`INDEX_W-1:0]  ret_index,
	output logic [`DATA_W-1:0]   ret_data
);

	slot_if sif [`BURST_SLOTS] ();

	burst_allocator u_alloc (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_type  (req_type),
		.req_bg    (req_bg),
		.req_bank  (req_bank),
		.req_row   (req_row),
		.req_col   (req_col),
		.req_data  (req_data),
		.req_index (req_index),
		.req_ready (req_ready),
		.fill      (sif)
	);

	for (genvar i = 0; i < `BURST_SLOTS; i++) begin : g_slot
		burst_slot u_slot (
			.clk   (clk),
			.rst_n (rst_n),
			.sif   (sif[i])
		);
	end

	burst_sequencer u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.drain     (sif),
		.cs_n      (cs_n),
		.ca        (ca),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.dm_n      (dm_n),
		.dq_in     (dq_in),
		.ret_valid (ret_valid),
		.ret_type  (ret_type),
		.ret_index (ret_index),
		.ret_data  (ret_data)
	);

endmodule

`default_nettype wire

// File: hw/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

module burst_sequencer import burst_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	slot_if.drain                 drain [`BURST_SLOTS],
	output logic                  cs_n,
	output logic [13:0]           ca,
	output logic [`DATA_W-1:0]    dq_out,
	output logic                  dq_oe,
	output logic [`DATA_W/8-1:0]  dm_n,
	input  logic [`DATA_W-1:0]    dq_in,
	output logic                  ret_valid,
	output req_type_e             ret_type,
	output logic [`INDEX_W-1:0]   ret_index,
	output logic [`DATA_W-1:0]    ret_data
);
	localparam int SEL_W  = $clog2(`BURST_SLOTS);
	localparam int BEAT_W = $clog2(`BURST_LEN);
	localparam int CNT_W  = 6;
	localparam logic [CNT_W-1:0] ACT_END = CNT_W'(`T_ACT_WAIT + 1);

	slot_state_e           st [`BURST_SLOTS];
	burst_addr_t           ad [`BURST_SLOTS];
	req_type_e             ty [`BURST_SLOTS];
	logic [`BURST_LEN-1:0] mk [`BURST_SLOTS];
	logic [`DATA_W-1:0]    bd [`BURST_SLOTS];
	logic [`INDEX_W-1:0]   bi [`BURST_SLOTS];

	ddr_cmd_e              cmd;        // command group in progress
	logic [CNT_W-1:0]      cnt;        // cycles into the group
	logic [SEL_W-1:0]      cur;        // slot in service
	logic                  serving;
	logic [SEL_W-1:0]      pick;
	logic                  any_full;
	logic                  start_go;
	logic [CNT_W-1:0]      data_first;
	logic [CNT_W-1:0]      rw_end;
	logic                  in_data;
	logic [BEAT_W-1:0]     beat;
	logic [BEAT_W-1:0]     first_col;
	logic                  ret_phase;
	logic                  pop;
	logic                  free_slot;
	burst_addr_t           a;
	logic [`BURST_LEN-1:0] cur_mask;

	always_comb begin
		pick     = '0;
		any_full = 1'b0;
		for (int i = `BURST_SLOTS - 1; i >= 0; i--) begin
			if (st[i] == full) begin
				pick     = SEL_W'(i);
				any_full = 1'b1;
			end
		end
	end

	assign a        = ad[cur];
	assign cur_mask = mk[cur];
	assign start_go = (cmd == cmd_none) && !serving && any_full;

	// pair, latency, then the beats
	assign data_first = (cmd == cmd_rd) ? CNT_W'(`RD_LAT + 2) : CNT_W'(`WR_LAT + 2);
	assign rw_end     = data_first + CNT_W'(`BURST_LEN - 1);
	assign in_data    = ((cmd == cmd_rd) || (cmd == cmd_wr)) && (cnt >= data_first);
	assign beat       = BEAT_W'(cnt - data_first);

	// lowest pending column goes back first
	always_comb begin
		first_col = '0;
		for (int b = `BURST_LEN - 1; b >= 0; b--) begin
			if (cur_mask[b])
				first_col = BEAT_W'(b);
		end
	end

	assign ret_phase = (cmd == cmd_none) && serving;
	assign pop       = ret_phase && (cur_mask != '0);
	assign free_slot = ret_phase && (cur_mask == '0);

	for (genvar i = 0; i < `BURST_SLOTS; i++) begin : g_drain
		assign st[i] = drain[i].state;
		assign ad[i] = drain[i].addr;
		assign ty[i] = drain[i].rtype;
		assign mk[i] = drain[i].mask;
		assign bd[i] = drain[i].beat_data;
		assign bi[i] = drain[i].beat_index;

		assign drain[i].start        = start_go && (pick == SEL_W'(i));
		assign drain[i].beat_sel     = in_data ? beat : first_col;
		assign drain[i].rd_beat_wr   = in_data && (cmd == cmd_rd) && (cur == SEL_W'(i));
		assign drain[i].rd_beat_data = dq_in;
		assign drain[i].ret_pop      = pop && (cur == SEL_W'(i));
		assign drain[i].ret_col      = first_col;
		assign drain[i].done         = free_slot && (cur == SEL_W'(i));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd     <= cmd_none;
			cnt     <= '0;
			cur     <= '0;
			serving <= 1'b0;
		end else begin
			case (cmd)
				cmd_none: begin
					if (start_go) begin
						cmd     <= cmd_act;
						cnt     <= '0;
						cur     <= pick;
						serving <= 1'b1;
					end else if (free_slot) begin
						serving <= 1'b0;
					end
				end
				cmd_act: begin
					if (cnt == ACT_END) begin
						cmd <= (ty[cur] == wr) ? cmd_wr : cmd_rd;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				cmd_rd, cmd_wr: begin
					if (cnt == rw_end) begin
						cmd <= cmd_pre;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				cmd_pre: begin
					if (cnt == CNT_W'(1)) begin
						cmd <= cmd_none; // on to the returns
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: cmd <= cmd_none;
			endcase
		end
	end

	// first cycle of a pair has cs_n low
	assign cs_n = !((cmd != cmd_none) && (cnt == '0));

	always_comb begin
		ca = '0;
		case (cmd)
			cmd_act: begin
				if (cnt == '0)
					ca = {4'b0000, a.bg, a.bank, a.row[3:0], 2'b00};
				else if (cnt == CNT_W'(1))
					ca = {2'b00, a.row[15:4]};
			end
			cmd_rd: begin
				if (cnt == '0)
					ca = {4'b0000, a.bg, a.bank, 1'b1, 5'b11101}; // bl16
				else if (cnt == CNT_W'(1))
					ca = {3'b000, 1'b1, 2'b00, a.col_hi, 2'b00}; // no auto precharge
			end
			cmd_wr: begin
				if (cnt == '0)
					ca = {4'b0000, a.bg, a.bank, 1'b1, 5'b01101};
				else if (cnt == CNT_W'(1))
					ca = {2'b00, &cur_mask, 1'b1, 2'b00, a.col_hi, 2'b00}; // full burst flag
			end
			cmd_pre: begin
				if (cnt == '0)
					ca = {4'b0000, a.bg, a.bank, 6'b011011};
			end
			default: ca = '0;
		endcase
	end

	// only requested beats go out on a write
	assign dq_oe  = in_data && (cmd == cmd_wr) && cur_mask[beat];
	assign dm_n   = dq_oe ? '0 : '1;
	assign dq_out = dq_oe ? bd[cur] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ret_valid <= 1'b0;
		else
			ret_valid <= pop;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			ret_type  <= ty[cur];
			ret_index <= bi[cur];
			ret_data  <= bd[cur];
		end
	end

endmodule

`default_nettype wire

// File: hw/burst_slot.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

module burst_slot import burst_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	slot_if.slot sif
);
	logic [`DATA_W-1:0]    beats [`BURST_LEN];
	logic [`INDEX_W-1:0]   idx   [`BURST_LEN];
	slot_state_e           state;
	burst_addr_t           addr;
	req_type_e             rtype;
	logic [`BURST_LEN-1:0] mask;  // one bit per requested beat

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= empty;
			mask  <= '0;
		end else begin
			case (state)
				empty:      if (sif.open) state <= filling;
				filling:    if (sif.close) state <= full;
				full:       if (sif.start) state <= in_service;
				in_service: if (sif.ret_pop) state <= returning; // first entry out
				returning:  if (sif.done) state <= empty;
				default:    state <= empty;
			endcase

			// later bit writes win over the clear
			if (sif.open)
				mask <= '0;
			if (sif.write)
				mask[sif.col_lo] <= 1'b1;
			if (sif.ret_pop)
				mask[sif.ret_col] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sif.open) begin
			addr  <= sif.open_addr;
			rtype <= sif.open_type;
		end
		if (sif.write) begin
			beats[sif.col_lo] <= sif.data;
			idx[sif.col_lo]   <= sif.index;
		end else if (sif.rd_beat_wr && mask[sif.beat_sel]) begin
			beats[sif.beat_sel] <= sif.rd_beat_data; // only requested beats
		end
	end

	assign sif.state      = state;
	assign sif.addr       = addr;
	assign sif.rtype      = rtype;
	assign sif.mask       = mask;
	assign sif.beat_data  = beats[sif.beat_sel];
	assign sif.beat_index = idx[sif.beat_sel];

endmodule

`default_nettype wire

// File: hw/burst_allocator.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

module burst_allocator import burst_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	input  req_type_e           req_type,
	input  logic [1:0]          req_bg,
	input  logic [1:0]          req_bank,
	input  logic [15:0]         req_row,
	input  logic [9:0]          req_col,
	input  logic [`DATA_W-1:0]  req_data,
	input  logic [`INDEX_W-1:0] req_index,
	output logic                req_ready,
	slot_if.fill                fill [`BURST_SLOTS]
);
	localparam int SEL_W = $clog2(`BURST_SLOTS);

	slot_state_e           st [`BURST_SLOTS];
	burst_addr_t           ad [`BURST_SLOTS];
	req_type_e             ty [`BURST_SLOTS];
	logic [`BURST_LEN-1:0] mk [`BURST_SLOTS];

	burst_addr_t      req_addr;
	logic [SEL_W-1:0] open_idx;     // slot currently gathering
	logic [SEL_W-1:0] first_empty;
	logic [SEL_W:0]   empty_cnt;
	logic             open_live;
	logic             take;
	logic             match;
	logic             do_open;
	logic             do_close;

	assign req_addr  = {req_bg, req_bank, req_row, req_col[9:4]};
	assign take      = req_valid && req_ready;
	assign open_live = (st[open_idx] == filling);

	// same burst and a column not seen yet
	assign match = open_live && (ty[open_idx] == req_type) && (ad[open_idx] == req_addr)
		&& !mk[open_idx][req_col[3:0]];

	assign do_open  = take && !match;
	assign do_close = open_live && (!req_valid || do_open); // idle cycle or mismatch

	// lowest empty slot and the number of empty ones
	always_comb begin
		first_empty = '0;
		empty_cnt   = '0;
		for (int i = `BURST_SLOTS - 1; i >= 0; i--) begin
			if (st[i] == empty) begin
				first_empty = SEL_W'(i);
				empty_cnt   = empty_cnt + 1'b1;
			end
		end
	end

	for (genvar i = 0; i < `BURST_SLOTS; i++) begin : g_fill
		assign st[i] = fill[i].state;
		assign ad[i] = fill[i].addr;
		assign ty[i] = fill[i].rtype;
		assign mk[i] = fill[i].mask;

		assign fill[i].open  = do_open && (first_empty == SEL_W'(i));
		assign fill[i].write = take && (match ? (open_idx == SEL_W'(i))
			: (first_empty == SEL_W'(i)));
		assign fill[i].close = do_close && (open_idx == SEL_W'(i));

		// payload goes to every slot, write/open pick the one
		assign fill[i].open_addr = req_addr;
		assign fill[i].open_type = req_type;
		assign fill[i].col_lo    = req_col[3:0];
		assign fill[i].data      = req_data;
		assign fill[i].index     = req_index;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_ready <= 1'b0;
			open_idx  <= '0;
		end else begin
			// keep one slot spare while requests keep coming
			req_ready <= (empty_cnt >= 2) || (empty_cnt == 1 && !req_valid);
			if (do_open)
				open_idx <= first_empty;
		end
	end

endmodule

`default_nettype wire

// File: hw/slot_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "burst_consts.svh"

interface slot_if
	import burst_pkg::*;
	();

	// fill side, from the allocator
	logic                          open;       // new burst, takes open_addr/open_type
	burst_addr_t                   open_addr;
	req_type_e                     open_type;
	logic                          write;      // store one beat
	logic [$clog2(`BURST_LEN)-1:0] col_lo;
	logic [`DATA_W-1:0]            data;
	logic [`INDEX_W-1:0]           index;
	logic                          close;      // filling -> full

	// status from the slot
	slot_state_e                   state;
	burst_addr_t                   addr;
	req_type_e                     rtype;
	logic [`BURST_LEN-1:0]         mask;
	logic [`DATA_W-1:0]            beat_data;  // beat read port at beat_sel
	logic [`INDEX_W-1:0]           beat_index;

	// drain side, from the sequencer
	logic                          start;      // full -> in_service
	logic [$clog2(`BURST_LEN)-1:0] beat_sel;
	logic                          rd_beat_wr;
	logic [`DATA_W-1:0]            rd_beat_data;
	logic                          ret_pop;    // clears mask[ret_col]
	logic [$clog2(`BURST_LEN)-1:0] ret_col;
	logic                          done;       // returning -> empty

	modport fill (
		output open, open_addr, open_type, write, col_lo, data, index, close,
		input  state, addr, rtype, mask
	);

	modport slot (
		input  open, open_addr, open_type, write, col_lo, data, index, close,
		input  start, beat_sel, rd_beat_wr, rd_beat_data, ret_pop, ret_col, done,
		output state, addr, rtype, mask, beat_data, beat_index
	);

	modport drain (
		output start, beat_sel, rd_beat_wr, rd_beat_data, ret_pop, ret_col, done,
		input  state, addr, rtype, mask, beat_data, beat_index
	);

endinterface

`default_nettype wire

// File: hw/burst_pkg.sv
`default_nettype none

package burst_pkg;

	// life cycle of one burst slot
	typedef enum logic [2:0] {
		empty,
		filling,
		full,
		in_service,
		returning
	} slot_state_e;

	typedef enum logic {
		rd,
		wr
	} req_type_e;

	// command pair on cs_n/ca
	typedef enum logic [2:0] {
		cmd_none,
		cmd_act,
		cmd_rd,
		cmd_wr,
		cmd_pre
	} ddr_cmd_e;

	// everything a burst shares, col[3:0] picks the beat
	typedef struct packed {
		logic [1:0]  bg;
		logic [1:0]  bank;
		logic [15:0] row;
		logic [5:0]  col_hi;
	} burst_addr_t;

endpackage

`default_nettype wire

// File: hw/burst_consts.svh
`ifndef BURST_CONSTS_SVH
`define BURST_CONSTS_SVH

// slot storage
`define BURST_SLOTS 4
`define BURST_LEN   16   // beats, indexed by col[3:0]
`define DATA_W      16
`define INDEX_W     4

// fixed waits in clk cycles
`define T_ACT_WAIT  4    // act pair end to rd/wr pair start
`define RD_LAT      6    // rd pair end to first beat on dq_in
`define WR_LAT      4    // wr pair end to first beat on dq_out

`endif
